// ==== Bender.yml ====
package:
  name: ifm_buffer

sources:
  - files:
      - design/ifm_buffer_pkg.sv
      - design/dual_port_ram.sv
      - design/ifm_bank.sv
      - design/bank_port_router.sv
      - design/output_select.sv
      - design/ifm_buffer_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/ifm_buffer_tb.sv

// ==== design/bank_port_router.sv ====
module bank_port_router (
	input  logic                      clk,
	input  ifm_buffer_pkg::bank_sel_t ifm_sel,
	input  logic                      wr_en_prev,
	input  logic                      rd_en_prev,
	input  ifm_buffer_pkg::addr_t     wr_addr_prev,
	input  ifm_buffer_pkg::addr_t     rd_addr_prev,
	input  logic                      rd_en_a_next,
	input  logic                      rd_en_b_next,
	input  ifm_buffer_pkg::addr_t     rd_addr_a_next,
	input  ifm_buffer_pkg::addr_t     rd_addr_b_next,
	output logic [ifm_buffer_pkg::NUM_BANKS-1:0] bank_wr_en,
	output logic [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_en_prev,
	output logic [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_en_a,
	output logic [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_en_b,
	output ifm_buffer_pkg::addr_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_wr_addr,
	output ifm_buffer_pkg::addr_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_addr_prev,
	output ifm_buffer_pkg::addr_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_addr_a,
	output ifm_buffer_pkg::addr_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_addr_b
);

	ifm_buffer_pkg::bank_sel_t prev_sel;

	// the next layer works on the bank just behind, bank 0 wraps to the last
	assign prev_sel = (ifm_sel == '0) ?
		ifm_buffer_pkg::bank_sel_t'(ifm_buffer_pkg::NUM_BANKS - 1) : ifm_sel - 1'b1;

	always_comb
	begin
		bank_wr_en = '0;
		bank_rd_en_prev = '0;
		bank_rd_en_a = '0;
		bank_rd_en_b = '0;
		bank_wr_addr = '0;
		bank_rd_addr_prev = '0;
		bank_rd_addr_a = '0;
		bank_rd_addr_b = '0;

		bank_wr_en[ifm_sel] = wr_en_prev;
		bank_rd_en_prev[ifm_sel] = rd_en_prev;
		bank_wr_addr[ifm_sel] = wr_addr_prev;
		bank_rd_addr_prev[ifm_sel] = rd_addr_prev;

		bank_rd_en_a[prev_sel] = rd_en_a_next;
		bank_rd_en_b[prev_sel] = rd_en_b_next;
		bank_rd_addr_a[prev_sel] = rd_addr_a_next;
		bank_rd_addr_b[prev_sel] = rd_addr_b_next;
	end

	// the previous layer and the next layer must never meet in one bank
	a_layers_apart: assert property (
		@(posedge clk) !(|((bank_wr_en | bank_rd_en_prev) & (bank_rd_en_a | bank_rd_en_b)))
	)
	else $error("previous-layer and next-layer accesses were routed to the same bank");

endmodule

// ==== design/dual_port_ram.sv ====
module dual_port_ram (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  en_a,
	input  logic                  we_a,
	input  logic                  en_b,
	input  ifm_buffer_pkg::addr_t addr_a,
	input  ifm_buffer_pkg::addr_t addr_b,
	input  ifm_buffer_pkg::data_t din_a,
	output ifm_buffer_pkg::data_t dout_a,
	output ifm_buffer_pkg::data_t dout_b
);

	ifm_buffer_pkg::data_t mem [ifm_buffer_pkg::MEM_DEPTH];

	// port A is the only write path
	always_ff @(posedge clk)
	begin
		if (en_a && we_a)
		begin
			mem[addr_a] <= din_a;
		end
	end

	// a write on port A leaves its read register untouched
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dout_a <= '0;
		end
		else if (en_a && !we_a)
		begin
			dout_a <= mem[addr_a];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dout_b <= '0;
		end
		else if (en_b)
		begin
			dout_b <= mem[addr_b];
		end
	end

endmodule

// ==== design/ifm_bank.sv ====
module ifm_bank (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   wr_en,
	input  logic                   rd_en_prev,
	input  logic                   rd_en_a,
	input  logic                   rd_en_b,
	input  ifm_buffer_pkg::addr_t  wr_addr,
	input  ifm_buffer_pkg::addr_t  rd_addr_prev,
	input  ifm_buffer_pkg::addr_t  rd_addr_a,
	input  ifm_buffer_pkg::addr_t  rd_addr_b,
	input  ifm_buffer_pkg::lanes_t din,
	output ifm_buffer_pkg::lanes_t dout_a,
	output ifm_buffer_pkg::lanes_t dout_b
);

	logic                  port_a_en;
	logic                  port_b_en;
	ifm_buffer_pkg::addr_t port_a_addr;
	ifm_buffer_pkg::addr_t port_b_addr;

	// idle requests arrive with address zero, so an OR merges them
	assign port_a_en = wr_en | rd_en_a;
	assign port_b_en = rd_en_prev | rd_en_b;
	assign port_a_addr = wr_addr | rd_addr_a;
	assign port_b_addr = rd_addr_prev | rd_addr_b;

	for (genvar lane = 0; lane < ifm_buffer_pkg::NUM_LANES; lane++)
	begin : g_lane
		dual_port_ram ram_i (
			.clk    (clk),
			.rst    (rst),
			.en_a   (port_a_en),
			.we_a   (wr_en),
			.en_b   (port_b_en),
			.addr_a (port_a_addr),
			.addr_b (port_b_addr),
			.din_a  (din[lane*ifm_buffer_pkg::DATA_WIDTH +: ifm_buffer_pkg::DATA_WIDTH]),
			.dout_a (dout_a[lane*ifm_buffer_pkg::DATA_WIDTH +: ifm_buffer_pkg::DATA_WIDTH]),
			.dout_b (dout_b[lane*ifm_buffer_pkg::DATA_WIDTH +: ifm_buffer_pkg::DATA_WIDTH])
		);
	end

	// the router must never give both sources of one port to the same bank
	a_port_a_one_source: assert property (
		@(posedge clk) disable iff (rst) !(wr_en && rd_en_a)
	)
	else $error("write and next-layer read A reached the same bank");

	a_port_b_one_source: assert property (
		@(posedge clk) disable iff (rst) !(rd_en_prev && rd_en_b)
	)
	else $error("read-back and next-layer read B reached the same bank");

endmodule

// ==== design/ifm_buffer_pkg.sv ====
package ifm_buffer_pkg;

	// ########################################################################
	// buffer geometry
	// ########################################################################

	localparam int DATA_WIDTH = 16;
	localparam int IFM_SIZE = 8;
	localparam int MEM_DEPTH = IFM_SIZE * IFM_SIZE;
	localparam int ADDR_WIDTH = $clog2(MEM_DEPTH);
	localparam int NUM_LANES = 3;
	localparam int NUM_BANKS = 4;
	localparam int SEL_WIDTH = $clog2(NUM_BANKS);

	// ########################################################################
	// types
	// ########################################################################

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [SEL_WIDTH-1:0] bank_sel_t;

	// lane 0 sits in the low bits
	typedef logic [NUM_LANES*DATA_WIDTH-1:0] lanes_t;

endpackage

// ==== design/ifm_buffer_top.sv ====
module ifm_buffer_top (
	input  logic                      clk,
	input  logic                      rst,
	input  ifm_buffer_pkg::bank_sel_t ifm_sel,
	input  logic                      wr_en_prev,
	input  logic                      rd_en_prev,
	input  ifm_buffer_pkg::addr_t     wr_addr_prev,
	input  ifm_buffer_pkg::addr_t     rd_addr_prev,
	input  logic                      rd_en_a_next,
	input  logic                      rd_en_b_next,
	input  ifm_buffer_pkg::addr_t     rd_addr_a_next,
	input  ifm_buffer_pkg::addr_t     rd_addr_b_next,
	input  ifm_buffer_pkg::lanes_t    data_in_prev,
	output ifm_buffer_pkg::lanes_t    data_out_prev,
	output ifm_buffer_pkg::lanes_t    data_out_a_next,
	output ifm_buffer_pkg::lanes_t    data_out_b_next
);

	logic [ifm_buffer_pkg::NUM_BANKS-1:0] bank_wr_en;
	logic [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_en_prev;
	logic [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_en_a;
	logic [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_en_b;

	ifm_buffer_pkg::addr_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_wr_addr;
	ifm_buffer_pkg::addr_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_addr_prev;
	ifm_buffer_pkg::addr_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_addr_a;
	ifm_buffer_pkg::addr_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_rd_addr_b;

	ifm_buffer_pkg::lanes_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_dout_a;
	ifm_buffer_pkg::lanes_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_dout_b;

	bank_port_router router_i (
		.clk               (clk),
		.ifm_sel           (ifm_sel),
		.wr_en_prev        (wr_en_prev),
		.rd_en_prev        (rd_en_prev),
		.wr_addr_prev      (wr_addr_prev),
		.rd_addr_prev      (rd_addr_prev),
		.rd_en_a_next      (rd_en_a_next),
		.rd_en_b_next      (rd_en_b_next),
		.rd_addr_a_next    (rd_addr_a_next),
		.rd_addr_b_next    (rd_addr_b_next),
		.bank_wr_en        (bank_wr_en),
		.bank_rd_en_prev   (bank_rd_en_prev),
		.bank_rd_en_a      (bank_rd_en_a),
		.bank_rd_en_b      (bank_rd_en_b),
		.bank_wr_addr      (bank_wr_addr),
		.bank_rd_addr_prev (bank_rd_addr_prev),
		.bank_rd_addr_a    (bank_rd_addr_a),
		.bank_rd_addr_b    (bank_rd_addr_b)
	);

	// every bank sees the same write data, only the selected one stores it
	for (genvar bank = 0; bank < ifm_buffer_pkg::NUM_BANKS; bank++)
	begin : g_bank
		ifm_bank bank_i (
			.clk          (clk),
			.rst          (rst),
			.wr_en        (bank_wr_en[bank]),
			.rd_en_prev   (bank_rd_en_prev[bank]),
			.rd_en_a      (bank_rd_en_a[bank]),
			.rd_en_b      (bank_rd_en_b[bank]),
			.wr_addr      (bank_wr_addr[bank]),
			.rd_addr_prev (bank_rd_addr_prev[bank]),
			.rd_addr_a    (bank_rd_addr_a[bank]),
			.rd_addr_b    (bank_rd_addr_b[bank]),
			.din          (data_in_prev),
			.dout_a       (bank_dout_a[bank]),
			.dout_b       (bank_dout_b[bank])
		);
	end

	output_select out_sel_i (
		.ifm_sel         (ifm_sel),
		.bank_dout_a     (bank_dout_a),
		.bank_dout_b     (bank_dout_b),
		.data_out_prev   (data_out_prev),
		.data_out_a_next (data_out_a_next),
		.data_out_b_next (data_out_b_next)
	);

endmodule

// ==== design/output_select.sv ====
module output_select (
	input  ifm_buffer_pkg::bank_sel_t ifm_sel,
	input  ifm_buffer_pkg::lanes_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_dout_a,
	input  ifm_buffer_pkg::lanes_t [ifm_buffer_pkg::NUM_BANKS-1:0] bank_dout_b,
	output ifm_buffer_pkg::lanes_t data_out_prev,
	output ifm_buffer_pkg::lanes_t data_out_a_next,
	output ifm_buffer_pkg::lanes_t data_out_b_next
);

	ifm_buffer_pkg::bank_sel_t prev_sel;

	assign prev_sel = (ifm_sel == '0) ?
		ifm_buffer_pkg::bank_sel_t'(ifm_buffer_pkg::NUM_BANKS - 1) : ifm_sel - 1'b1;

	// read-back always comes out of port B of the writing bank
	assign data_out_prev = bank_dout_b[ifm_sel];

	// both next-layer ports look at the bank behind
	assign data_out_a_next = bank_dout_a[prev_sel];
	assign data_out_b_next = bank_dout_b[prev_sel];

endmodule

// ==== tb.f ====
+incdir+test
design/ifm_buffer_pkg.sv
design/dual_port_ram.sv
design/ifm_bank.sv
design/bank_port_router.sv
design/output_select.sv
design/ifm_buffer_top.sv
test/ifm_buffer_tb.sv

// ==== test/ifm_buffer_model.svh ====
`ifndef IFM_BUFFER_MODEL_SVH
`define IFM_BUFFER_MODEL_SVH

// ############################################################################
// reference model of the bank array and the per-bank read registers
// ############################################################################

// the three lanes of a bank share every address, so one entry holds all of them
ifm_buffer_pkg::lanes_t model_mem [ifm_buffer_pkg::NUM_BANKS][ifm_buffer_pkg::MEM_DEPTH];
ifm_buffer_pkg::lanes_t model_reg_a [ifm_buffer_pkg::NUM_BANKS];
ifm_buffer_pkg::lanes_t model_reg_b [ifm_buffer_pkg::NUM_BANKS];

logic [31:0] rng_state;

// the bank that the next layer reads, one behind the writing bank with wraparound
function automatic int behind(input int sel);
	return (sel + ifm_buffer_pkg::NUM_BANKS - 1) % ifm_buffer_pkg::NUM_BANKS;
endfunction

function automatic void clear_model();
	for (int b = 0; b < ifm_buffer_pkg::NUM_BANKS; b++)
	begin
		model_reg_a[b] = '0;
		model_reg_b[b] = '0;
		for (int a = 0; a < ifm_buffer_pkg::MEM_DEPTH; a++)
		begin
			model_mem[b][a] = 'x;
		end
	end
endfunction

// one clock edge: reads see the contents from before this edge's write
function automatic void update_model(
	input int                     sel,
	input logic                   wr_en,
	input ifm_buffer_pkg::addr_t  wr_addr,
	input ifm_buffer_pkg::lanes_t din,
	input logic                   rd_prev,
	input ifm_buffer_pkg::addr_t  prev_addr,
	input logic                   rd_a,
	input ifm_buffer_pkg::addr_t  a_addr,
	input logic                   rd_b,
	input ifm_buffer_pkg::addr_t  b_addr
);
	int back;

	back = behind(sel);
	if (rd_prev)
		model_reg_b[sel] = model_mem[sel][prev_addr];
	if (rd_a)
		model_reg_a[back] = model_mem[back][a_addr];
	if (rd_b)
		model_reg_b[back] = model_mem[back][b_addr];
	if (wr_en)
		model_mem[sel][wr_addr] = din;
endfunction

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;

	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

`endif

// ==== test/ifm_buffer_tb.sv ====
module ifm_buffer_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 8;
	localparam int FILL_CYCLES = ifm_buffer_pkg::NUM_BANKS * ifm_buffer_pkg::MEM_DEPTH;
	localparam int READBACK_CYCLES = ifm_buffer_pkg::NUM_BANKS * ifm_buffer_pkg::MEM_DEPTH;
	localparam int NEXT_PER_BANK = 32;
	localparam int NEXT_CYCLES = ifm_buffer_pkg::NUM_BANKS * NEXT_PER_BANK;
	localparam int ISO_WRITES = 16;
	localparam int ISO_CYCLES = ifm_buffer_pkg::NUM_BANKS *
		(ISO_WRITES + (ifm_buffer_pkg::NUM_BANKS - 1) * ifm_buffer_pkg::MEM_DEPTH);
	localparam int MIXED_CYCLES = 1000;
	localparam int TEST_CYCLES = FILL_CYCLES + READBACK_CYCLES + NEXT_CYCLES +
		ISO_CYCLES + MIXED_CYCLES;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + RESET_CYCLES;

	logic                      clk;
	logic                      rst;
	ifm_buffer_pkg::bank_sel_t ifm_sel;
	logic                      wr_en_prev;
	logic                      rd_en_prev;
	ifm_buffer_pkg::addr_t     wr_addr_prev;
	ifm_buffer_pkg::addr_t     rd_addr_prev;
	logic                      rd_en_a_next;
	logic                      rd_en_b_next;
	ifm_buffer_pkg::addr_t     rd_addr_a_next;
	ifm_buffer_pkg::addr_t     rd_addr_b_next;
	ifm_buffer_pkg::lanes_t    data_in_prev;
	ifm_buffer_pkg::lanes_t    data_out_prev;
	ifm_buffer_pkg::lanes_t    data_out_a_next;
	ifm_buffer_pkg::lanes_t    data_out_b_next;

	int error_count;
	int check_count;
	int cycle_count;

	`include "ifm_buffer_model.svh"

	ifm_buffer_top dut_i (
		.clk             (clk),
		.rst             (rst),
		.ifm_sel         (ifm_sel),
		.wr_en_prev      (wr_en_prev),
		.rd_en_prev      (rd_en_prev),
		.wr_addr_prev    (wr_addr_prev),
		.rd_addr_prev    (rd_addr_prev),
		.rd_en_a_next    (rd_en_a_next),
		.rd_en_b_next    (rd_en_b_next),
		.rd_addr_a_next  (rd_addr_a_next),
		.rd_addr_b_next  (rd_addr_b_next),
		.data_in_prev    (data_in_prev),
		.data_out_prev   (data_out_prev),
		.data_out_a_next (data_out_a_next),
		.data_out_b_next (data_out_b_next)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
		begin
			$display("the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("%0d checks, %0d errors", check_count, error_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic ifm_buffer_pkg::lanes_t random_lanes();
		logic [63:0] wide;

		wide = {next_random(), next_random()};
		return wide[ifm_buffer_pkg::NUM_LANES*ifm_buffer_pkg::DATA_WIDTH-1:0];
	endfunction

	function automatic ifm_buffer_pkg::addr_t random_addr();
		logic [31:0] r;

		r = next_random();
		return r[ifm_buffer_pkg::ADDR_WIDTH-1:0];
	endfunction

	task automatic check_value(
		input string                  name,
		input ifm_buffer_pkg::lanes_t expected,
		input ifm_buffer_pkg::lanes_t actual
	);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// called 2 ns after an edge, returns 2 ns after the next one
	task automatic drive_cycle(
		input int                     sel,
		input logic                   wr_en,
		input ifm_buffer_pkg::addr_t  wr_addr,
		input ifm_buffer_pkg::lanes_t din,
		input logic                   rd_prev,
		input ifm_buffer_pkg::addr_t  prev_addr,
		input logic                   rd_a,
		input ifm_buffer_pkg::addr_t  a_addr,
		input logic                   rd_b,
		input ifm_buffer_pkg::addr_t  b_addr,
		input string                  name
	);
		ifm_sel = ifm_buffer_pkg::bank_sel_t'(sel);
		wr_en_prev = wr_en;
		wr_addr_prev = wr_addr;
		data_in_prev = din;
		rd_en_prev = rd_prev;
		rd_addr_prev = prev_addr;
		rd_en_a_next = rd_a;
		rd_addr_a_next = a_addr;
		rd_en_b_next = rd_b;
		rd_addr_b_next = b_addr;
		@(posedge clk);
		update_model(sel, wr_en, wr_addr, din, rd_prev, prev_addr, rd_a, a_addr, rd_b, b_addr);
		#1;
		check_value({name, " prev"}, model_reg_b[sel], data_out_prev);
		check_value({name, " next a"}, model_reg_a[behind(sel)], data_out_a_next);
		check_value({name, " next b"}, model_reg_b[behind(sel)], data_out_b_next);
		#1;
	endtask

	// ########################################################################
	// test sequence
	// ########################################################################

	initial
	begin
		logic [31:0] r;
		int          sel;

		rng_state = 32'h1e29;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		clk = 1'b0;
		rst = 1'b1;
		ifm_sel = '0;
		wr_en_prev = 1'b0;
		rd_en_prev = 1'b0;
		wr_addr_prev = '0;
		rd_addr_prev = '0;
		rd_en_a_next = 1'b0;
		rd_en_b_next = 1'b0;
		rd_addr_a_next = '0;
		rd_addr_b_next = '0;
		data_in_prev = '0;
		clear_model();

		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
		check_value("reset prev", '0, data_out_prev);
		check_value("reset next a", '0, data_out_a_next);
		check_value("reset next b", '0, data_out_b_next);

		// fill every bank, then read each one back through the previous-layer port
		for (int b = 0; b < ifm_buffer_pkg::NUM_BANKS; b++)
			for (int a = 0; a < ifm_buffer_pkg::MEM_DEPTH; a++)
				drive_cycle(b, 1'b1, a, random_lanes(), 1'b0, '0, 1'b0, '0, 1'b0, '0, "write");
		for (int b = 0; b < ifm_buffer_pkg::NUM_BANKS; b++)
			for (int a = 0; a < ifm_buffer_pkg::MEM_DEPTH; a++)
				drive_cycle(b, 1'b0, '0, '0, 1'b1, a, 1'b0, '0, 1'b0, '0, "readback");

		// selection 0 makes the next layer read bank 3
		for (int s = 0; s < ifm_buffer_pkg::NUM_BANKS; s++)
			repeat (NEXT_PER_BANK)
				drive_cycle(s, 1'b0, '0, '0, 1'b0, '0, 1'b1, random_addr(), 1'b1,
					random_addr(), "next_read");

		// writes under one selection, then a full sweep of the other banks
		for (int s = 0; s < ifm_buffer_pkg::NUM_BANKS; s++)
		begin
			repeat (ISO_WRITES)
				drive_cycle(s, 1'b1, random_addr(), random_lanes(), 1'b0, '0, 1'b0, '0,
					1'b0, '0, "isolation write");
			for (int b = 0; b < ifm_buffer_pkg::NUM_BANKS; b++)
				if (b != s)
					for (int a = 0; a < ifm_buffer_pkg::MEM_DEPTH; a++)
						drive_cycle(b, 1'b0, '0, '0, 1'b1, a, 1'b0, '0, 1'b0, '0, "isolation");
		end

		sel = 0;
		repeat (MIXED_CYCLES)
		begin
			r = next_random();
			if (r[2:0] == 3'd0)
				sel = r[4:3];
			drive_cycle(sel, r[5], random_addr(), random_lanes(), r[6], random_addr(), r[7],
				random_addr(), r[8], random_addr(), "mixed");
		end

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
